//--- logic/scope_pkg.sv
package scope_pkg;

    ////////////////////
    // sample path
    ////////////////////
    localparam int ADC_BITS  = 14;
    localparam int FRAME_LEN = 16;
    localparam int FRAME_AW  = 4;

    ////////////////////
    // adc serial port
    ////////////////////
    localparam int SPI_DIV   = 4;                    // cycles per half sclk period
    localparam int SPI_CNT_W = $clog2(2 * SPI_DIV);
    localparam int CFG_BITS  = 24;                   // 16 bit instruction then 8 bit data
    localparam int CFG_BIT_W = $clog2(CFG_BITS);
    localparam int CFG_LEN   = 3;
    localparam int CFG_IDX_W = $clog2(CFG_LEN + 1);

    localparam logic [CFG_BITS-1:0] cfg_table [CFG_LEN] = '{
        24'h00003c,                                  // soft reset
        24'h001400,                                  // output mode, offset binary
        24'h00ff01                                   // transfer to active registers
    };

    ////////////////////
    // uart
    ////////////////////
    localparam int         BAUD_DIV  = 8;            // cycles per bit
    localparam int         BAUD_W    = $clog2(BAUD_DIV);
    localparam logic [7:0] SYNC_BYTE = 8'ha5;

    localparam logic [2:0] FS_IDLE = 3'd0;
    localparam logic [2:0] FS_SYNC = 3'd1;
    localparam logic [2:0] FS_HI   = 3'd2;
    localparam logic [2:0] FS_LO   = 3'd3;
    localparam logic [2:0] FS_LAST = 3'd4;

    // one buffer word, read as a sample or as two uart bytes
    typedef union packed {
        struct packed {
            logic [15-ADC_BITS:0] pad;
            logic [ADC_BITS-1:0]  sample;
        } raw;
        struct packed {
            logic [7:0] hi_byte;
            logic [7:0] lo_byte;
        } bytes;
    } sample_word_u;

endpackage

//--- logic/frame_buf_if.sv
`timescale 1ns/1ps

interface frame_buf_if
    import scope_pkg::*;
();

    logic                frame_full;                 // level, a whole frame is waiting
    logic                frame_taken;                // one cycle pulse from the sender
    logic [FRAME_AW-1:0] rd_addr;
    sample_word_u        rd_data;                    // valid one cycle after rd_addr

    modport capture (
        output frame_full,
        output rd_data,
        input  rd_addr,
        input  frame_taken
    );

    modport send (
        input  frame_full,
        input  rd_data,
        output rd_addr,
        output frame_taken
    );

endinterface

//--- logic/adc_spi_config.sv
`timescale 1ns/1ps

module adc_spi_config
    import scope_pkg::*;
(
    input  logic adc_dco_clock_p,
    input  logic i_rst_n,
    output logic o_adc_cs,
    output logic o_adc_sclk,
    output logic o_adc_sdio,
    output logic o_init_done
);

    logic [SPI_CNT_W-1:0] div_cnt;                   // position inside a bit or a cs gap
    logic [CFG_BIT_W-1:0] bit_cnt;
    logic [CFG_IDX_W-1:0] entry_idx;
    logic [CFG_BITS-1:0]  shift_reg;
    logic                 div_half;
    logic                 div_end;

    assign div_half   = (div_cnt == SPI_CNT_W'(SPI_DIV - 1));
    assign div_end    = (div_cnt == SPI_CNT_W'(2 * SPI_DIV - 1));
    assign o_adc_sdio = shift_reg[CFG_BITS-1];       // msb first

    always_ff @(posedge adc_dco_clock_p) begin
        if (!i_rst_n) begin
            o_adc_cs    <= 1'b1;
            o_adc_sclk  <= 1'b0;
            o_init_done <= 1'b0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            entry_idx   <= '0;
            shift_reg   <= '0;
        end else if (o_adc_cs) begin
            // cs high: count out the gap, then open the next write
            if (!o_init_done) begin
                if (entry_idx == CFG_IDX_W'(CFG_LEN)) begin
                    o_init_done <= 1'b1;             // the whole table has gone out
                end else if (div_end) begin
                    o_adc_cs  <= 1'b0;
                    div_cnt   <= '0;
                    bit_cnt   <= '0;
                    shift_reg <= cfg_table[entry_idx];
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end else begin
            if (div_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (div_half) begin
                o_adc_sclk <= 1'b1;                  // the adc samples sdio on this edge
            end

            if (div_end) begin
                o_adc_sclk <= 1'b0;
                if (bit_cnt == CFG_BIT_W'(CFG_BITS - 1)) begin
                    o_adc_cs  <= 1'b1;               // close the write with the last fall
                    entry_idx <= entry_idx + 1'b1;
                end else begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    shift_reg <= {shift_reg[CFG_BITS-2:0], 1'b0};
                end
            end
        end
    end

endmodule

//--- logic/sample_capture.sv
`timescale 1ns/1ps

module sample_capture
    import scope_pkg::*;
(
    input  logic                adc_dco_clock_p,
    input  logic                i_rst_n,
    input  logic                i_init_done,
    input  logic [ADC_BITS-1:0] i_adc_data,
    frame_buf_if.capture        buf_if
);

    logic [ADC_BITS-1:0] adc_q;                      // bus register, one cycle behind the pins
    logic [ADC_BITS-1:0] mem [FRAME_LEN];
    logic [FRAME_AW-1:0] wr_addr;
    logic                wr_en;

    // armed whenever the buffer is not holding a frame
    assign wr_en = i_init_done && !buf_if.frame_full;

    ////////////////////
    // data path
    ////////////////////
    always_ff @(posedge adc_dco_clock_p) begin
        adc_q <= i_adc_data;

        if (wr_en) begin
            mem[wr_addr] <= adc_q;
        end

        buf_if.rd_data.raw.pad    <= '0;
        buf_if.rd_data.raw.sample <= mem[buf_if.rd_addr];
    end

    ////////////////////
    // fill control
    ////////////////////
    always_ff @(posedge adc_dco_clock_p) begin
        if (!i_rst_n) begin
            wr_addr           <= '0;
            buf_if.frame_full <= 1'b0;
        end else begin
            if (buf_if.frame_taken) begin
                buf_if.frame_full <= 1'b0;           // re-arm for the next frame
            end

            if (wr_en) begin
                if (wr_addr == FRAME_AW'(FRAME_LEN - 1)) begin
                    wr_addr           <= '0;
                    buf_if.frame_full <= 1'b1;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/frame_sender.sv
`timescale 1ns/1ps

module frame_sender
    import scope_pkg::*;
(
    input  logic       adc_dco_clock_p,
    input  logic       i_rst_n,
    frame_buf_if.send  buf_if,
    output logic [7:0] o_tx_data,
    output logic       o_tx_start,
    input  logic       i_tx_busy
);

    logic [2:0] state;
    logic       tx_ready;
    logic       last_addr;

    // busy only shows up the cycle after a start, so skip that cycle
    assign tx_ready  = !i_tx_busy && !o_tx_start;
    assign last_addr = (buf_if.rd_addr == FRAME_AW'(FRAME_LEN - 1));

    always_ff @(posedge adc_dco_clock_p) begin
        if (!i_rst_n) begin
            state              <= FS_IDLE;
            o_tx_start         <= 1'b0;
            buf_if.rd_addr     <= '0;
            buf_if.frame_taken <= 1'b0;
        end else begin
            o_tx_start         <= 1'b0;
            buf_if.frame_taken <= 1'b0;

            case (state)
                FS_IDLE: begin
                    if (buf_if.frame_full && !buf_if.frame_taken) begin
                        state <= FS_SYNC;
                    end
                end
                FS_SYNC: begin
                    if (tx_ready) begin
                        o_tx_start <= 1'b1;
                        state      <= FS_HI;
                    end
                end
                FS_HI: begin
                    if (tx_ready) begin
                        o_tx_start <= 1'b1;
                        state      <= FS_LO;
                    end
                end
                FS_LO: begin
                    if (tx_ready) begin
                        o_tx_start     <= 1'b1;
                        buf_if.rd_addr <= buf_if.rd_addr + 1'b1;  // wraps back to zero
                        state          <= last_addr ? FS_LAST : FS_HI;
                    end
                end
                FS_LAST: begin
                    buf_if.frame_taken <= 1'b1;      // last byte went to the uart last cycle
                    state              <= FS_IDLE;
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge adc_dco_clock_p) begin
        if (tx_ready) begin
            case (state)
                FS_SYNC: o_tx_data <= SYNC_BYTE;
                FS_HI:   o_tx_data <= buf_if.rd_data.bytes.hi_byte;
                FS_LO:   o_tx_data <= buf_if.rd_data.bytes.lo_byte;
                default: o_tx_data <= o_tx_data;
            endcase
        end
    end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
    import scope_pkg::*;
(
    input  logic       adc_dco_clock_p,
    input  logic       i_rst_n,
    input  logic [7:0] i_tx_data,
    input  logic       i_tx_start,
    output logic       o_tx_busy,
    output logic       o_tx
);

    logic [BAUD_W-1:0] baud_cnt;
    logic [3:0]        bit_cnt;                      // 0 is the start bit, 9 the stop bit
    logic [8:0]        shift_reg;                    // data bits, then the stop bit
    logic              baud_end;

    assign baud_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

    always_ff @(posedge adc_dco_clock_p) begin
        if (!i_rst_n) begin
            o_tx_busy <= 1'b0;
            o_tx      <= 1'b1;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end else if (!o_tx_busy) begin
            if (i_tx_start) begin
                o_tx_busy <= 1'b1;
                o_tx      <= 1'b0;                   // start bit
                shift_reg <= {1'b1, i_tx_data};
                baud_cnt  <= '0;
                bit_cnt   <= '0;
            end
        end else if (baud_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                o_tx_busy <= 1'b0;                   // stop bit done, line stays high
            end else begin
                o_tx      <= shift_reg[0];           // lsb first
                shift_reg <= {1'b1, shift_reg[8:1]};
                bit_cnt   <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

//--- logic/scope_top.sv
`timescale 1ns/1ps

module scope_top
    import scope_pkg::*;
(
    input  logic                adc_dco_clock_p,
    input  logic                i_rst_n,
    input  logic [ADC_BITS-1:0] i_adc_data,
    output logic                o_adc_cs,
    output logic                o_adc_sclk,
    output logic                o_adc_sdio,
    output logic                o_tx,
    output logic                o_led0_g
);

    logic       init_done;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    frame_buf_if frame_buf ();

    adc_spi_config u_adc_spi_config (
        .adc_dco_clock_p (adc_dco_clock_p),
        .i_rst_n         (i_rst_n),
        .o_adc_cs        (o_adc_cs),
        .o_adc_sclk      (o_adc_sclk),
        .o_adc_sdio      (o_adc_sdio),
        .o_init_done     (init_done)
    );

    sample_capture u_sample_capture (
        .adc_dco_clock_p (adc_dco_clock_p),
        .i_rst_n         (i_rst_n),
        .i_init_done     (init_done),
        .i_adc_data      (i_adc_data),
        .buf_if          (frame_buf.capture)
    );

    frame_sender u_frame_sender (
        .adc_dco_clock_p (adc_dco_clock_p),
        .i_rst_n         (i_rst_n),
        .buf_if          (frame_buf.send),
        .o_tx_data       (tx_data),
        .o_tx_start      (tx_start),
        .i_tx_busy       (tx_busy)
    );

    uart_tx u_uart_tx (
        .adc_dco_clock_p (adc_dco_clock_p),
        .i_rst_n         (i_rst_n),
        .i_tx_data       (tx_data),
        .i_tx_start      (tx_start),
        .o_tx_busy       (tx_busy),
        .o_tx            (o_tx)
    );

    assign o_led0_g = init_done;                     // green once the adc is configured

endmodule

//--- dv/scope_chk.sv
`timescale 1ns/1ps

module scope_chk (
    input logic adc_dco_clock_p,
    input logic i_rst_n,
    input logic i_adc_cs,
    input logic i_adc_sclk,
    input logic i_tx,
    input logic i_tx_busy,
    input logic i_led0_g
);

    logic rst_seen = 1'b0;                           // set once reset has been clocked in
    int   fail_cnt = 0;

    always_ff @(posedge adc_dco_clock_p) begin
        if (!i_rst_n) begin
            rst_seen <= 1'b1;
        end
    end

    cs_high_in_reset: assert property (@(posedge adc_dco_clock_p)
        (rst_seen && !i_rst_n) |-> i_adc_cs)
        else begin
            $error("adc chip select went low during reset");
            fail_cnt++;
        end

    // a falling sclk may close the write, so look at cs as it was before the edge
    sclk_inside_cs: assert property (@(posedge adc_dco_clock_p) disable iff (!i_rst_n)
        (i_adc_sclk != $past(i_adc_sclk)) |-> !$past(i_adc_cs))
        else begin
            $error("adc sclk toggled while chip select was high");
            fail_cnt++;
        end

    tx_idle_high: assert property (@(posedge adc_dco_clock_p) disable iff (!i_rst_n)
        !i_tx_busy |-> i_tx)
        else begin
            $error("uart line low while the transmitter is idle");
            fail_cnt++;
        end

    led_stays_on: assert property (@(posedge adc_dco_clock_p) disable iff (!i_rst_n)
        i_led0_g |=> i_led0_g)
        else begin
            $error("green led fell after it was lit");
            fail_cnt++;
        end

endmodule

bind scope_top scope_chk u_scope_chk (
    .adc_dco_clock_p (adc_dco_clock_p),
    .i_rst_n         (i_rst_n),
    .i_adc_cs        (o_adc_cs),
    .i_adc_sclk      (o_adc_sclk),
    .i_tx            (o_tx),
    .i_tx_busy       (tx_busy),
    .i_led0_g        (o_led0_g)
);

//--- dv/scope_tb.sv
`timescale 1ns/1ps

module scope_tb;
    import scope_pkg::*;

    localparam int N_FRAMES       = 3;
    localparam int RESET_CYCLES   = 5;
    localparam int FRAME_BYTES    = 2 * FRAME_LEN;
    localparam int CFG_CYCLES     = CFG_LEN * (CFG_BITS + 1) * 2 * SPI_DIV;
    localparam int FRAME_CYCLES   = (FRAME_BYTES + 1) * (10 * BAUD_DIV + 2) + FRAME_LEN;
    localparam int TIMEOUT_CYCLES = CFG_CYCLES + (N_FRAMES + 1) * FRAME_CYCLES;
    localparam int T_RESET        = 0;
    localparam int T_CFG          = 1;
    localparam int T_INIT         = 2;
    localparam int T_FORMAT       = 3;
    localparam int T_CONTENT      = 4;

    logic                     adc_dco_clock_p;
    logic                     rst_n;
    logic [ADC_BITS-1:0]      adc_data;
    logic                     adc_cs;
    logic                     adc_sclk;
    logic                     adc_sdio;
    logic                     tx;
    logic                     led0_g;

    logic [ADC_BITS-1:0]      adc_count;
    logic [CFG_BITS-1:0]      spi_shift;
    logic [CFG_BITS-1:0]      cfg_words [$];
    logic [8*FRAME_BYTES-1:0] frame_q [$];
    int                       err_cnt [5] = '{default: 0};
    int                       cycle_count = 0;
    int                       spi_bits = 0;
    int                       frames_rx = 0;
    int                       frames_done = 0;
    int                       tests_passed = 0;
    int                       tests_failed = 0;
    int                       last_cs_rise = 0;
    bit                       cs_prev = 1'b1;
    bit                       led_seen = 1'b0;

    scope_top UUT (
        .adc_dco_clock_p (adc_dco_clock_p),
        .i_rst_n         (rst_n),
        .i_adc_data      (adc_data),
        .o_adc_cs        (adc_cs),
        .o_adc_sclk      (adc_sclk),
        .o_adc_sdio      (adc_sdio),
        .o_tx            (tx),
        .o_led0_g        (led0_g)
    );

    ////////////////////
    // helpers
    ////////////////////
    function automatic string test_name(input int id);
        case (id)
            T_RESET: return "reset_state";
            T_CFG:   return "config_writes";
            T_INIT:  return "init_done";
            T_FORMAT: return "frame_format";
            default: return "frame_contents";
        endcase
    endfunction

    task automatic check_value(input int id, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("error: %s expected %0h actual %0h", test_name(id), expected, actual);
            err_cnt[id]++;
        end
    endtask

    task automatic check_true(input int id, input bit cond, input string what);
        assert (cond) else begin
            $display("%s: %s", test_name(id), what);
            err_cnt[id]++;
        end
    endtask

    task automatic report_test(input int id);
        if (err_cnt[id] == 0) begin
            $display("test %s passed", test_name(id));
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", test_name(id), err_cnt[id]);
            tests_failed++;
        end
    endtask

    task automatic check_reset_state();
        check_value(T_RESET, 32'd1, 32'(adc_cs));
        check_value(T_RESET, 32'd0, 32'(adc_sclk));
        check_value(T_RESET, 32'd1, 32'(tx));
        check_value(T_RESET, 32'd0, 32'(led0_g));
    endtask

    // each sample goes out as a hi byte with two zero pad bits, then the lo byte
    function automatic logic [8*FRAME_BYTES-1:0] expected_frame(input logic [ADC_BITS-1:0] first);
        logic [8*FRAME_BYTES-1:0] frame;
        logic [ADC_BITS-1:0]      value;
        int                       i;
        frame = '0;
        for (i = 0; i < FRAME_LEN; i++) begin
            value                = first + ADC_BITS'(i);  // wraps at 14 bits
            frame[16*i +: 8]     = 8'(value >> 8);
            frame[16*i + 8 +: 8] = value[7:0];
        end
        return frame;
    endfunction

    // called at the negedge where the start bit was first seen low
    task automatic receive_byte(output logic [7:0] data, output bit start_ok, output bit stop_ok);
        int i;
        repeat (BAUD_DIV / 2 - 1) @(negedge adc_dco_clock_p);
        start_ok = (tx === 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge adc_dco_clock_p);
            data[i] = tx;                                 // lsb first
        end
        repeat (BAUD_DIV) @(negedge adc_dco_clock_p);
        stop_ok = (tx === 1'b1);
    endtask

    ////////////////////
    // clock, stimulus and timeout
    ////////////////////
    initial begin
        adc_dco_clock_p = 1'b0;
        forever #5 adc_dco_clock_p = ~adc_dco_clock_p;
    end

    initial begin : adc_stimulus
        void'($urandom(68));
        adc_count = ADC_BITS'($urandom);
        adc_data  = adc_count;
        forever begin
            @(posedge adc_dco_clock_p);
            #1;
            adc_count = adc_count + ADC_BITS'(1);
            adc_data  = adc_count;
        end
    end

    always @(posedge adc_dco_clock_p) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d frames checked",
                     cycle_count, frames_done, N_FRAMES);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////
    // decoders and compare
    ////////////////////
    always @(posedge adc_sclk or posedge adc_cs) begin
        if (adc_cs === 1'b0) begin
            spi_shift = {spi_shift[CFG_BITS-2:0], adc_sdio};  // adc samples on the rising sclk
            spi_bits++;
        end else if (spi_bits > 0) begin
            check_value(T_CFG, CFG_BITS, spi_bits);
            cfg_words.push_back(spi_shift);
            spi_bits = 0;
        end
    end

    always @(negedge adc_dco_clock_p) begin : led_monitor
        int i;
        if (rst_n) begin
            if (adc_cs && !cs_prev) last_cs_rise = cycle_count;
            if (led0_g && !led_seen) begin
                led_seen = 1'b1;
                check_true(T_INIT, last_cs_rise < cycle_count && cfg_words.size() == CFG_LEN,
                           "green led rose before the last configuration write ended");
                check_value(T_CFG, CFG_LEN, cfg_words.size());
                for (i = 0; i < CFG_LEN && i < cfg_words.size(); i++) begin
                    check_value(T_CFG, 32'(cfg_table[i]), 32'(cfg_words[i]));
                end
                report_test(T_CFG);
            end else if (led_seen) begin
                check_true(T_INIT, led0_g, "green led fell after init done");
                check_true(T_INIT, adc_cs, "chip select fell again after init done");
            end
        end
        cs_prev = adc_cs;
    end

    initial begin : uart_decoder
        logic [7:0]               rx_byte;
        logic [8*FRAME_BYTES-1:0] rx_frame;
        bit                       start_ok;
        bit                       stop_ok;
        int                       byte_idx;
        byte_idx = 0;
        rx_frame = '0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge adc_dco_clock_p);
            if (tx === 1'b0) begin
                receive_byte(rx_byte, start_ok, stop_ok);
                check_true(T_FORMAT, start_ok, "start bit did not stay low to mid-bit");
                check_true(T_FORMAT, stop_ok, "stop bit was not high");
                if (byte_idx == 0) begin
                    check_value(T_FORMAT, 32'(SYNC_BYTE), 32'(rx_byte));
                    if (rx_byte == SYNC_BYTE) byte_idx = 1;   // otherwise hunt for the next sync
                end else begin
                    rx_frame[8*(byte_idx-1) +: 8] = rx_byte;
                    if (byte_idx % 2 == 1) begin
                        check_true(T_FORMAT, rx_byte[7:6] == 2'b00,
                                   "hi byte has its pad bits set");
                    end
                    byte_idx++;
                    if (byte_idx > FRAME_BYTES) begin
                        frame_q.push_back(rx_frame);
                        frames_rx++;
                        byte_idx = 0;
                    end
                end
            end
        end
    end

    initial begin : frame_compare
        logic [8*FRAME_BYTES-1:0] got;
        logic [8*FRAME_BYTES-1:0] exp;
        logic [ADC_BITS-1:0]      first;
        int                       j;
        forever begin
            wait (frames_rx > frames_done);
            got   = frame_q.pop_front();
            first = {got[ADC_BITS-9:0], got[15:8]};
            exp   = expected_frame(first);
            for (j = 0; j < FRAME_BYTES; j++) begin
                check_value(T_CONTENT, 32'(exp[8*j +: 8]), 32'(got[8*j +: 8]));
            end
            frames_done++;
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin : main_sequence
        int total_errs;
        int i;
        rst_n = 1'b0;
        repeat (RESET_CYCLES - 1) begin
            @(negedge adc_dco_clock_p);
            check_reset_state();
        end
        @(posedge adc_dco_clock_p);
        #1;
        rst_n = 1'b1;
        @(negedge adc_dco_clock_p);
        check_reset_state();
        report_test(T_RESET);

        wait (frames_done == N_FRAMES);
        check_true(T_INIT, led_seen && led0_g, "green led is not lit at the end of the run");
        report_test(T_INIT);
        report_test(T_FORMAT);
        report_test(T_CONTENT);

        total_errs = UUT.u_scope_chk.fail_cnt;       // bound assertion failures count too
        for (i = 0; i < 5; i++) total_errs += err_cnt[i];
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errs);
        if (total_errs == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
logic/scope_pkg.sv
logic/frame_buf_if.sv
logic/adc_spi_config.sv
logic/sample_capture.sv
logic/frame_sender.sv
logic/uart_tx.sv
logic/scope_top.sv
dv/scope_chk.sv
dv/scope_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := scope_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ** PASS **
FAIL_MSG  := ** FAIL **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; \
	else echo "simulation passed"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
